/* list.f */
logic/rvc_pkg.sv
logic/rvc_ifs.sv
logic/rvc_decode.sv
logic/rvc_execute.sv
logic/rvc_result.sv
logic/rvc_core.sv
test/rvc_checker.sv
test/rvc_tb.sv

/* logic/rvc_core.sv */
`timescale 1ns/1ns

module rvc_core (
  input  logic        clock_i,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  logic [15:0] instr_i,
  output logic        retire_o,
  output logic        illegal_o,
  output logic        ebreak_o,
  output logic        wb_wren_o,
  output logic [4:0]  wb_waddr_o,
  output logic [31:0] wb_wdata_o,
  output logic [31:0] pc_o
);

  rvc_decode_if dec_if ();
  rvc_result_if res_if ();

  rvc_decode u_decode (
    .instr_i (rvc_pkg::rvc_instr_type'(instr_i)),
    .dec     (dec_if)
  );

  rvc_execute u_execute (
    .clock_i       (clock_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .dec           (dec_if),
    .res           (res_if),
    .pc_o          (pc_o)
  );

  rvc_result u_result (
    .clock_i    (clock_i),
    .rst_i      (rst_i),
    .res        (res_if),
    .retire_o   (retire_o),
    .illegal_o  (illegal_o),
    .ebreak_o   (ebreak_o),
    .wb_wren_o  (wb_wren_o),
    .wb_waddr_o (wb_waddr_o),
    .wb_wdata_o (wb_wdata_o)
  );

endmodule

/* logic/rvc_decode.sv */
`timescale 1ns/1ns

module rvc_decode (
  input  rvc_pkg::rvc_instr_type instr_i,
  rvc_decode_if.dec              dec
);

  logic [15:0] iw;
  logic [31:0] imm_lwsp, imm_swsp, imm_lswr;
  logic [31:0] imm_j, imm_b, imm_w, imm_i, imm_u, imm_p, imm_sh;
  logic [4:0]  rs1_w, rs2_w, rs1_c, rs2_c;
  logic [2:0]  funct9;

  assign iw = instr_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Immediate forms.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign imm_lwsp = {24'b0, iw[3:2], iw[12], iw[6:4], 2'b0};
  assign imm_swsp = {24'b0, iw[8:7], iw[12:9], 2'b0};
  assign imm_lswr = {25'b0, iw[5], iw[12:10], iw[6], 2'b0};
  assign imm_j    = {{21{iw[12]}}, iw[8], iw[10:9], iw[6], iw[7], iw[2], iw[11], iw[5:3], 1'b0};
  assign imm_b    = {{24{iw[12]}}, iw[6:5], iw[2], iw[11:10], iw[4:3], 1'b0};
  assign imm_w    = {22'b0, iw[10:7], iw[12:11], iw[5], iw[6], 2'b0}; // Scaled by four.
  assign imm_i    = {{27{iw[12]}}, iw[6:2]};
  assign imm_u    = {{15{iw[12]}}, iw[6:2], 12'b0};
  assign imm_p    = {{23{iw[12]}}, iw[4:3], iw[5], iw[2], iw[6], 4'b0};
  assign imm_sh   = {27'b0, instr_i.ci.imm5};

  assign rs1_w  = instr_i.ci.rd;
  assign rs2_w  = instr_i.ci.imm5;
  assign rs1_c  = {2'b01, instr_i.cb.rs1p}; // Compact fields map onto x8 to x15.
  assign rs2_c  = {2'b01, instr_i.cb.rs2p};
  assign funct9 = {instr_i.cb.bit12, instr_i.cb.funct8};

  always_comb begin
    dec.imm    = '0;
    dec.waddr  = rs1_w;
    dec.raddr1 = rs1_w;
    dec.raddr2 = rs2_w;
    dec.wren   = 1'b0;
    dec.rden1  = 1'b0;
    dec.rden2  = 1'b0;
    dec.lui    = 1'b0;
    dec.jal    = 1'b0;
    dec.jalr   = 1'b0;
    dec.branch = 1'b0;
    dec.ebreak = 1'b0;
    dec.valid  = 1'b1;
    dec.alu_op = rvc_pkg::init_alu_op;
    dec.bcu_op = rvc_pkg::init_bcu_op;
    dec.lsu_op = rvc_pkg::init_lsu_op;

    case (instr_i.ci.op)
      rvc_pkg::opcode_c0: begin
        case (instr_i.ci.funct3)
          rvc_pkg::c0_addispn: begin
            dec.imm            = imm_w;
            dec.waddr          = rs2_c;
            dec.raddr1         = 5'd2;
            dec.wren           = |imm_w;
            dec.rden1          = |imm_w;
            dec.alu_op.alu_add = |imm_w;
            dec.valid          = |imm_w; // The all-zero word lands here.
          end
          rvc_pkg::c0_lw: begin
            dec.imm           = imm_lswr;
            dec.waddr         = rs2_c;
            dec.raddr1        = rs1_c;
            dec.wren          = 1'b1;
            dec.rden1         = 1'b1;
            dec.lsu_op.lsu_lw = 1'b1;
          end
          rvc_pkg::c0_sw: begin
            dec.imm           = imm_lswr;
            dec.raddr1        = rs1_c;
            dec.raddr2        = rs2_c;
            dec.rden1         = 1'b1;
            dec.rden2         = 1'b1;
            dec.lsu_op.lsu_sw = 1'b1;
          end
          default: dec.valid = 1'b0;
        endcase
      end
      rvc_pkg::opcode_c1: begin
        case (instr_i.ci.funct3)
          rvc_pkg::c1_addi: begin
            dec.imm            = imm_i;
            dec.wren           = |imm_i;
            dec.rden1          = |imm_i;
            dec.alu_op.alu_add = |imm_i;
          end
          rvc_pkg::c1_jal: begin
            dec.imm   = imm_j;
            dec.waddr = 5'd1;
            dec.wren  = 1'b1;
            dec.jal   = 1'b1;
          end
          rvc_pkg::c1_li: begin
            dec.imm            = imm_i; // Operand 1 stays zero.
            dec.wren           = 1'b1;
            dec.alu_op.alu_add = 1'b1;
          end
          rvc_pkg::c1_lui: begin
            if (rs1_w == 5'd2) begin
              dec.imm            = imm_p;
              dec.wren           = |imm_p;
              dec.rden1          = |imm_p;
              dec.alu_op.alu_add = |imm_p;
            end else begin
              dec.imm  = imm_u;
              dec.wren = |imm_u;
              dec.lui  = |imm_u;
            end
          end
          rvc_pkg::c1_alu: begin
            dec.imm    = imm_i;
            dec.waddr  = rs1_c;
            dec.raddr1 = rs1_c;
            dec.raddr2 = rs2_c;
            case (instr_i.cb.funct6)
              2'd0, 2'd1: begin
                dec.imm            = imm_sh;
                dec.wren           = |imm_sh;
                dec.rden1          = |imm_sh;
                dec.alu_op.alu_srl = |imm_sh && !instr_i.cb.funct6[0];
                dec.alu_op.alu_sra = |imm_sh && instr_i.cb.funct6[0];
                dec.valid          = |imm_sh;
              end
              2'd2: begin
                dec.wren           = 1'b1;
                dec.rden1          = 1'b1;
                dec.alu_op.alu_and = 1'b1;
              end
              default: begin
                dec.wren  = !funct9[2];
                dec.rden1 = !funct9[2];
                dec.rden2 = !funct9[2];
                dec.valid = !funct9[2]; // Codes 4 to 7 are RV64 only.
                case (funct9)
                  3'd0:    dec.alu_op.alu_sub = 1'b1;
                  3'd1:    dec.alu_op.alu_xor = 1'b1;
                  3'd2:    dec.alu_op.alu_or  = 1'b1;
                  3'd3:    dec.alu_op.alu_and = 1'b1;
                  default: dec.alu_op = rvc_pkg::init_alu_op;
                endcase
              end
            endcase
          end
          rvc_pkg::c1_j: begin
            dec.imm   = imm_j;
            dec.waddr = 5'd0;
            dec.jal   = 1'b1;
          end
          default: begin // c.beqz and c.bnez compare against x0.
            dec.imm            = imm_b;
            dec.raddr1         = rs1_c;
            dec.raddr2         = 5'd0;
            dec.rden1          = 1'b1;
            dec.rden2          = 1'b1;
            dec.branch         = 1'b1;
            dec.bcu_op.bcu_beq = (instr_i.ci.funct3 == rvc_pkg::c1_beqz);
            dec.bcu_op.bcu_bne = (instr_i.ci.funct3 == rvc_pkg::c1_bnez);
          end
        endcase
      end
      rvc_pkg::opcode_c2: begin
        case (instr_i.ci.funct3)
          rvc_pkg::c2_slli: begin
            dec.imm            = imm_sh;
            dec.wren           = |imm_sh;
            dec.rden1          = |imm_sh;
            dec.alu_op.alu_sll = |imm_sh;
            dec.valid          = |imm_sh;
          end
          rvc_pkg::c2_lwsp: begin
            dec.imm           = imm_lwsp;
            dec.raddr1        = 5'd2;
            dec.wren          = 1'b1;
            dec.rden1         = 1'b1;
            dec.lsu_op.lsu_lw = 1'b1;
          end
          rvc_pkg::c2_alu: begin
            if (rs2_w != 5'd0) begin
              dec.wren           = 1'b1;
              dec.rden1          = instr_i.ci.bit12; // c.add reads rd, c.mv does not.
              dec.rden2          = 1'b1;
              dec.alu_op.alu_add = 1'b1;
            end else if (rs1_w == 5'd0) begin
              dec.ebreak = instr_i.ci.bit12;
              dec.valid  = instr_i.ci.bit12; // c.jr with x0 is reserved.
            end else begin
              dec.waddr = instr_i.ci.bit12 ? 5'd1 : 5'd0;
              dec.wren  = instr_i.ci.bit12;
              dec.rden1 = 1'b1;
              dec.jalr  = 1'b1;
            end
          end
          rvc_pkg::c2_swsp: begin
            dec.imm           = imm_swsp;
            dec.raddr1        = 5'd2;
            dec.rden1         = 1'b1;
            dec.rden2         = 1'b1;
            dec.lsu_op.lsu_sw = 1'b1;
          end
          default: dec.valid = 1'b0;
        endcase
      end
      default: dec.valid = 1'b0;
    endcase
  end

endmodule

/* logic/rvc_execute.sv */
`timescale 1ns/1ns

module rvc_execute (
  input  logic        clock_i,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  rvc_decode_if.exe   dec,
  rvc_result_if.exe   res,
  output logic [31:0] pc_o
);

  logic [31:0] rf [1:31];
  logic [31:0] pc;
  logic [31:0] rs1, rs2, op1, op2;
  logic [31:0] alu_res, link, pc_next;
  logic        taken;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operands with bypass from result.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rs1 = (dec.raddr1 == 5'd0) ? '0 :
               (res.fwd_wren && res.fwd_waddr == dec.raddr1) ? res.fwd_wdata : rf[dec.raddr1];
  assign rs2 = (dec.raddr2 == 5'd0) ? '0 :
               (res.fwd_wren && res.fwd_waddr == dec.raddr2) ? res.fwd_wdata : rf[dec.raddr2];

  assign op1  = dec.rden1 ? rs1 : '0;
  assign op2  = dec.rden2 ? rs2 : dec.imm;
  assign link = pc + 32'd2;

  always_comb begin
    case (1'b1)
      dec.alu_op.alu_add: alu_res = op1 + op2;
      dec.alu_op.alu_sub: alu_res = op1 - op2;
      dec.alu_op.alu_sll: alu_res = op1 << op2[4:0];
      dec.alu_op.alu_srl: alu_res = op1 >> op2[4:0];
      dec.alu_op.alu_sra: alu_res = $signed(op1) >>> op2[4:0];
      dec.alu_op.alu_xor: alu_res = op1 ^ op2;
      dec.alu_op.alu_or:  alu_res = op1 | op2;
      dec.alu_op.alu_and: alu_res = op1 & op2;
      default:            alu_res = '0;
    endcase
  end

  assign taken = (dec.bcu_op.bcu_beq && rs1 == rs2) || (dec.bcu_op.bcu_bne && rs1 != rs2);

  always_comb begin
    pc_next = link; // Illegal instructions fall through here too.
    if (dec.valid && (dec.jal || (dec.branch && taken))) begin
      pc_next = pc + dec.imm;
    end else if (dec.valid && dec.jalr) begin
      pc_next = {rs1[31:1], 1'b0};
    end
  end

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      pc <= '0;
    end else if (instr_valid_i) begin
      pc <= pc_next;
    end
  end

  assign pc_o = pc;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (res.fwd_wren) begin
      rf[res.fwd_waddr] <= res.fwd_wdata; // The result stage never forwards x0.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result stage register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      res.retire  <= 1'b0;
      res.illegal <= 1'b0;
      res.ebreak  <= 1'b0;
      res.wren    <= 1'b0;
      res.lsu_op  <= rvc_pkg::init_lsu_op;
    end else begin
      res.retire  <= instr_valid_i;
      res.illegal <= instr_valid_i && !dec.valid;
      res.ebreak  <= instr_valid_i && dec.valid && dec.ebreak;
      res.wren    <= instr_valid_i && dec.wren;
      res.lsu_op  <= instr_valid_i ? dec.lsu_op : rvc_pkg::init_lsu_op;
    end
  end

  always_ff @(posedge clock_i) begin
    res.waddr <= dec.waddr;
    res.wdata <= dec.lui ? dec.imm : (dec.jal || dec.jalr) ? link : alu_res;
    res.addr  <= rs1 + dec.imm;
    res.sdata <= rs2;
    res.pc    <= pc;
  end

  // Decode never asks for two kinds of control transfer or memory access at once.
  a_one_kind: assert property (@(posedge clock_i) disable iff (rst_i)
    instr_valid_i && dec.valid |->
      $onehot0({dec.lsu_op.lsu_lw, dec.lsu_op.lsu_sw, dec.jal, dec.jalr, dec.branch}));

  // Decode clears wren and the store flag of every reserved encoding.
  a_illegal_quiet: assert property (@(posedge clock_i) disable iff (rst_i)
    res.illegal |-> !res.wren && !res.lsu_op.lsu_sw);

endmodule

/* logic/rvc_ifs.sv */
`timescale 1ns/1ns

interface rvc_decode_if;
  logic [31:0]         imm;
  logic [4:0]          waddr;
  logic [4:0]          raddr1;
  logic [4:0]          raddr2;
  logic                wren;
  logic                rden1;
  logic                rden2;
  logic                lui;
  logic                jal;
  logic                jalr;
  logic                branch;
  logic                ebreak;
  logic                valid;
  rvc_pkg::alu_op_type alu_op;
  rvc_pkg::bcu_op_type bcu_op;
  rvc_pkg::lsu_op_type lsu_op;

  modport dec (output imm, waddr, raddr1, raddr2, wren, rden1, rden2, lui, jal, jalr,
               branch, ebreak, valid, alu_op, bcu_op, lsu_op);
  modport exe (input imm, waddr, raddr1, raddr2, wren, rden1, rden2, lui, jal, jalr,
               branch, ebreak, valid, alu_op, bcu_op, lsu_op);
endinterface

interface rvc_result_if;
  logic                retire;
  logic                illegal;
  logic                ebreak;
  logic                wren;
  logic [4:0]          waddr;
  logic [31:0]         wdata;
  rvc_pkg::lsu_op_type lsu_op;
  logic [31:0]         addr;
  logic [31:0]         sdata;
  logic [31:0]         pc;
  // Final write of the result stage with the load data already selected.
  logic                fwd_wren;
  logic [4:0]          fwd_waddr;
  logic [31:0]         fwd_wdata;

  modport exe (output retire, illegal, ebreak, wren, waddr, wdata, lsu_op, addr, sdata, pc,
               input fwd_wren, fwd_waddr, fwd_wdata);
  modport res (input retire, illegal, ebreak, wren, waddr, wdata, lsu_op, addr, sdata, pc,
               output fwd_wren, fwd_waddr, fwd_wdata);
endinterface

/* logic/rvc_pkg.sv */
package rvc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Quadrants and funct3 codes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] opcode_c0 = 2'b00;
  localparam logic [1:0] opcode_c1 = 2'b01;
  localparam logic [1:0] opcode_c2 = 2'b10;

  localparam logic [2:0] c0_addispn = 3'b000;
  localparam logic [2:0] c0_lw      = 3'b010;
  localparam logic [2:0] c0_sw      = 3'b110;

  localparam logic [2:0] c1_addi = 3'b000;
  localparam logic [2:0] c1_jal  = 3'b001;
  localparam logic [2:0] c1_li   = 3'b010;
  localparam logic [2:0] c1_lui  = 3'b011; // Also c.addi16sp when rd is x2.
  localparam logic [2:0] c1_alu  = 3'b100;
  localparam logic [2:0] c1_j    = 3'b101;
  localparam logic [2:0] c1_beqz = 3'b110;
  localparam logic [2:0] c1_bnez = 3'b111;

  localparam logic [2:0] c2_slli = 3'b000;
  localparam logic [2:0] c2_lwsp = 3'b010;
  localparam logic [2:0] c2_alu  = 3'b100; // The jr, mv, ebreak, jalr and add group.
  localparam logic [2:0] c2_swsp = 3'b110;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operation flags, one hot.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic alu_add;
    logic alu_sub;
    logic alu_sll;
    logic alu_srl;
    logic alu_sra;
    logic alu_xor;
    logic alu_or;
    logic alu_and;
  } alu_op_type;

  typedef struct packed {
    logic bcu_beq;
    logic bcu_bne;
  } bcu_op_type;

  typedef struct packed {
    logic lsu_lw;
    logic lsu_sw;
  } lsu_op_type;

  localparam alu_op_type init_alu_op = '0;
  localparam bcu_op_type init_bcu_op = '0;
  localparam lsu_op_type init_lsu_op = '0;

  // Wide register view.
  typedef struct packed {
    logic [2:0] funct3;
    logic       bit12;
    logic [4:0] rd;
    logic [4:0] imm5;
    logic [1:0] op;
  } rvc_ci_type;

  // Compact register view. The fields rs1p and rs2p select x8 to x15.
  typedef struct packed {
    logic [2:0] funct3;
    logic       bit12;
    logic [1:0] funct6;
    logic [2:0] rs1p;
    logic [1:0] funct8;
    logic [2:0] rs2p;
    logic [1:0] op;
  } rvc_cb_type;

  typedef union packed {
    rvc_ci_type ci;
    rvc_cb_type cb;
  } rvc_instr_type;

  localparam int dmem_words = 64;
  localparam int dmem_aw    = $clog2(dmem_words);

endpackage

/* logic/rvc_result.sv */
`timescale 1ns/1ns

module rvc_result (
  input  logic        clock_i,
  input  logic        rst_i,
  rvc_result_if.res   res,
  output logic        retire_o,
  output logic        illegal_o,
  output logic        ebreak_o,
  output logic        wb_wren_o,
  output logic [4:0]  wb_waddr_o,
  output logic [31:0] wb_wdata_o
);

  logic [31:0]                 dmem [rvc_pkg::dmem_words];
  logic [rvc_pkg::dmem_aw-1:0] idx;
  logic [31:0]                 ldata;

  assign idx   = res.addr[rvc_pkg::dmem_aw+1:2]; // Upper address bits wrap.
  assign ldata = dmem[idx];

  // Write to x0 is dropped here and reported as no write.
  assign res.fwd_wren  = res.wren && (res.waddr != 5'd0);
  assign res.fwd_waddr = res.waddr;
  assign res.fwd_wdata = res.lsu_op.lsu_lw ? ldata : res.wdata;

  assign retire_o   = res.retire;
  assign illegal_o  = res.illegal;
  assign ebreak_o   = res.ebreak;
  assign wb_wren_o  = res.fwd_wren;
  assign wb_waddr_o = res.fwd_waddr;
  assign wb_wdata_o = res.fwd_wdata;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      for (int i = 0; i < rvc_pkg::dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (res.retire && res.lsu_op.lsu_sw) begin
      dmem[idx] <= res.sdata;
    end
  end

  a_word_aligned: assert property (@(posedge clock_i) disable iff (rst_i)
    res.retire && (res.lsu_op.lsu_lw || res.lsu_op.lsu_sw) |-> res.addr[1:0] == 2'b00)
    else $error("misaligned word access from pc %h", res.pc);

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rvc_tb -f list.f -o rvc_sim \
  && ./obj_dir/rvc_sim > sim.log 2>&1 \
  || echo "Build or simulation run did not complete."
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/rvc_checker.sv */
`timescale 1ns/1ns

module rvc_checker (
  input  logic         clock_i,
  input  logic         rst_i,
  input  logic         retire_i,
  input  logic         illegal_i,
  input  logic         ebreak_i,
  input  logic         wb_wren_i,
  input  logic [4:0]   wb_waddr_i,
  input  logic [31:0]  wb_wdata_i,
  input  logic [31:0]  pc_i,
  input  logic [127:0] exp_name_i,
  input  logic         exp_strobe_i,
  input  logic         exp_illegal_i,
  input  logic         exp_ebreak_i,
  input  logic         exp_wren_i,
  input  logic [4:0]   exp_waddr_i,
  input  logic [31:0]  exp_wdata_i,
  input  logic [31:0]  exp_pc_i,
  output int           checks_o,
  output int           errors_o
);

  int checks = 0;
  int errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  task automatic compare(input string field, input logic [31:0] expv, input logic [31:0] actv);
    checks = checks + 1;
    if (actv !== expv) begin
      errors = errors + 1;
      $display("** Error at %0t: %0s, %0s expected %h, actual %h",
               $time, exp_name_i, field, expv, actv);
    end
  endtask

  // Retire outputs are stable in the second half of the cycle.
  always @(negedge clock_i) begin
    if (!rst_i) begin
      compare("retire", {31'b0, exp_strobe_i}, {31'b0, retire_i});
      if (retire_i && exp_strobe_i) begin
        compare("illegal", {31'b0, exp_illegal_i}, {31'b0, illegal_i});
        compare("ebreak", {31'b0, exp_ebreak_i}, {31'b0, ebreak_i});
        compare("wren", {31'b0, exp_wren_i}, {31'b0, wb_wren_i});
        if (exp_wren_i) begin
          compare("waddr", {27'b0, exp_waddr_i}, {27'b0, wb_waddr_i});
          compare("wdata", exp_wdata_i, wb_wdata_i);
        end
      end
      if (exp_strobe_i) begin
        compare("pc", exp_pc_i, pc_i); // The pc moves at the accepting edge.
      end
    end
  end

endmodule

/* test/rvc_tb.sv */
`timescale 1ns/1ns

module rvc_tb;

  typedef struct packed {
    logic [127:0] name;
    logic [15:0]  instr;
    logic         strobe;
    logic [2:0]   flags; // Expected illegal, ebreak and wren.
    logic [4:0]   waddr;
    logic [31:0]  wdata;
    logic [31:0]  pc;
  } test_type;

  logic        clock;
  logic        rst;
  logic        instr_valid;
  logic [15:0] instr;
  logic        retire, illegal, ebreak, wb_wren;
  logic [4:0]  wb_waddr;
  logic [31:0] wb_wdata, pc;
  test_type    tests [$];
  test_type    exp = '0;
  int          cycles = 0;
  int          limit = 0;
  int          checks, errors;

  rvc_core dut (
    .clock_i       (clock),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .retire_o      (retire),
    .illegal_o     (illegal),
    .ebreak_o      (ebreak),
    .wb_wren_o     (wb_wren),
    .wb_waddr_o    (wb_waddr),
    .wb_wdata_o    (wb_wdata),
    .pc_o          (pc)
  );

  rvc_checker u_checker (
    .clock_i       (clock),
    .rst_i         (rst),
    .retire_i      (retire),
    .illegal_i     (illegal),
    .ebreak_i      (ebreak),
    .wb_wren_i     (wb_wren),
    .wb_waddr_i    (wb_waddr),
    .wb_wdata_i    (wb_wdata),
    .pc_i          (pc),
    .exp_name_i    (exp.name),
    .exp_strobe_i  (exp.strobe),
    .exp_illegal_i (exp.flags[2]),
    .exp_ebreak_i  (exp.flags[1]),
    .exp_wren_i    (exp.flags[0]),
    .exp_waddr_i   (exp.waddr),
    .exp_wdata_i   (exp.wdata),
    .exp_pc_i      (exp.pc),
    .checks_o      (checks),
    .errors_o      (errors)
  );

  always #20 clock = ~clock;

  task automatic add_test(input logic [127:0] name, input logic [15:0] iw, input logic strobe,
                          input logic [2:0] flags, input logic [4:0] waddr,
                          input logic [31:0] wdata, input logic [31:0] next_pc);
    tests.push_back(test_type'{name, iw, strobe, flags, waddr, wdata, next_pc});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program that starts from pc 0 and a zeroed register file.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_table();
    // Name, instruction, strobe, flags, waddr, wdata, pc after the instruction.
    add_test("c.li x8", 16'h4415, 1'b1, 3'b001, 5'd8, 32'h0000_0005, 32'd2);
    add_test("c.addi x8 bypass", 16'h1475, 1'b1, 3'b001, 5'd8, 32'h0000_0002, 32'd4);
    add_test("c.lui x9", 16'h74FD, 1'b1, 3'b001, 5'd9, 32'hFFFF_F000, 32'd6);
    add_test("c.addi16sp", 16'h6121, 1'b1, 3'b001, 5'd2, 32'h0000_0040, 32'd8);
    add_test("c.addi4spn x10", 16'h0028, 1'b1, 3'b001, 5'd10, 32'h0000_0048, 32'd10);
    add_test("c.slli x8", 16'h0412, 1'b1, 3'b001, 5'd8, 32'h0000_0020, 32'd12);
    add_test("c.srai x9", 16'h8491, 1'b1, 3'b001, 5'd9, 32'hFFFF_FF00, 32'd14);
    add_test("c.srli x9", 16'h80A1, 1'b1, 3'b001, 5'd9, 32'h00FF_FFFF, 32'd16);
    add_test("c.andi x9", 16'h98C1, 1'b1, 3'b001, 5'd9, 32'h00FF_FFF0, 32'd18);
    add_test("c.sub x8", 16'h8C05, 1'b1, 3'b001, 5'd8, 32'hFF00_0030, 32'd20);
    add_test("c.xor x8", 16'h8C25, 1'b1, 3'b001, 5'd8, 32'hFFFF_FFC0, 32'd22);
    add_test("c.or x10", 16'h8D45, 1'b1, 3'b001, 5'd10, 32'h00FF_FFF8, 32'd24);
    add_test("c.and x8", 16'h8C69, 1'b1, 3'b001, 5'd8, 32'h00FF_FFC0, 32'd26);
    add_test("c.mv x11", 16'h85A2, 1'b1, 3'b001, 5'd11, 32'h00FF_FFC0, 32'd28);
    add_test("c.add x11", 16'h958A, 1'b1, 3'b001, 5'd11, 32'h0100_0000, 32'd30);
    add_test("c.sw", 16'hC14C, 1'b1, 3'b000, 5'd0, 32'h0, 32'd32);
    add_test("c.lw x12", 16'h4150, 1'b1, 3'b001, 5'd12, 32'h0100_0000, 32'd34);
    add_test("c.swsp", 16'hC622, 1'b1, 3'b000, 5'd0, 32'h0, 32'd36);
    add_test("c.lwsp x13", 16'h46B2, 1'b1, 3'b001, 5'd13, 32'h00FF_FFC0, 32'd38);
    add_test("c.addi load use", 16'h0685, 1'b1, 3'b001, 5'd13, 32'h00FF_FFC1, 32'd40);
    add_test("c.j", 16'hA021, 1'b1, 3'b000, 5'd0, 32'h0, 32'd48);
    add_test("c.jal", 16'h2801, 1'b1, 3'b001, 5'd1, 32'd50, 32'd64);
    add_test("c.li x14", 16'h4779, 1'b1, 3'b001, 5'd14, 32'd30, 32'd66);
    add_test("c.jr x14", 16'h8702, 1'b1, 3'b000, 5'd0, 32'h0, 32'd30);
    add_test("c.jalr x1", 16'h9082, 1'b1, 3'b001, 5'd1, 32'd32, 32'd50);
    add_test("c.beqz taken", 16'hC399, 1'b1, 3'b000, 5'd0, 32'h0, 32'd56);
    add_test("c.beqz not taken", 16'hC019, 1'b1, 3'b000, 5'd0, 32'h0, 32'd58);
    add_test("c.bnez taken", 16'hFC75, 1'b1, 3'b000, 5'd0, 32'h0, 32'd54);
    add_test("c.bnez not taken", 16'hFFF5, 1'b1, 3'b000, 5'd0, 32'h0, 32'd56);
    add_test("c.addi hint", 16'h0401, 1'b1, 3'b000, 5'd0, 32'h0, 32'd58);
    add_test("c.li x0 hint", 16'h4015, 1'b1, 3'b000, 5'd0, 32'h0, 32'd60);
    add_test("all zero word", 16'h0000, 1'b1, 3'b100, 5'd0, 32'h0, 32'd62);
    add_test("c.jr x0", 16'h8002, 1'b1, 3'b100, 5'd0, 32'h0, 32'd64);
    add_test("c.fld", 16'h2000, 1'b1, 3'b100, 5'd0, 32'h0, 32'd66);
    add_test("c.subw", 16'h9C01, 1'b1, 3'b100, 5'd0, 32'h0, 32'd68);
    add_test("c.ebreak", 16'h9002, 1'b1, 3'b010, 5'd0, 32'h0, 32'd70);
    add_test("idle cycle", 16'h4415, 1'b0, 3'b000, 5'd0, 32'h0, 32'd70);
    add_test("c.li x15", 16'h57FD, 1'b1, 3'b001, 5'd15, 32'hFFFF_FFFF, 32'd72);
    add_test("c.add x15 x15", 16'h97BE, 1'b1, 3'b001, 5'd15, 32'hFFFF_FFFE, 32'd74);
  endtask

  initial begin
    clock = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    build_table();
    limit = tests.size() * 2 + 8 + 20;
    repeat (8) @(posedge clock);
    rst <= 1'b0;
    // Expected fields trail the instruction by one cycle, as retire does.
    for (int k = 0; k <= tests.size(); k++) begin
      @(posedge clock);
      if (k < tests.size()) begin
        instr       <= tests[k].instr;
        instr_valid <= tests[k].strobe;
      end else begin
        instr_valid <= 1'b0;
      end
      if (k > 0) begin
        exp <= tests[k-1];
      end
    end
    @(posedge clock);
    exp <= '0;
    @(posedge clock);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run did not end within %0d cycles.", limit);
      $display("Verification failed");
      $finish;
    end
  end

endmodule
